// File: project.f
+incdir+hw
hw/ap_pkg.sv
hw/int_sqrt.sv
hw/magnitude.sv
hw/band_accumulator.sv
hw/spectrum_to_mel.sv
tests/tb_spectrum_to_mel.sv

// File: Bender.yml
package:
  name: spectrum_to_mel

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/ap_pkg.sv
      - hw/int_sqrt.sv
      - hw/magnitude.sv
      - hw/band_accumulator.sv
      - hw/spectrum_to_mel.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_spectrum_to_mel.sv

// File: tests/tb_spectrum_to_mel.sv
// clock, reset, bin stimulus, band model, band compare and timeout for the mel band top level
`timescale 1ns/1ps
`default_nettype none

`include "ap_defines.svh"

module tb_spectrum_to_mel;

    localparam int PERIOD       = 20;
    localparam int RST_CYCLES   = 2;
    localparam int IDLE_CYCLES  = 40;   // quiet time after reset with no band allowed
    localparam int DENSE_FRAMES = 5;    // corner, timing, three random
    localparam int GAP_FRAMES   = 2;
    localparam int MAX_GAP      = 3;    // idle cycles before a bin in gap frames
    localparam int TAIL_CYCLES  = 24;   // catches stray bands after the last one
    localparam int CORNER_N     = 20;
    localparam int TOTAL_BANDS  = (DENSE_FRAMES + GAP_FRAMES) * `AP_NUM_BANDS;
    localparam int STIM_CYCLES  = RST_CYCLES + IDLE_CYCLES
                                + `AP_NUM_BINS * (DENSE_FRAMES + GAP_FRAMES * (MAX_GAP + 1));
    localparam int CYCLE_LIMIT  = STIM_CYCLES + 64;

    // ------------------------------
    // dut signals
    // ------------------------------
    logic                clk;
    logic                rst;
    ap_pkg::fft_part_t   in_re;
    ap_pkg::fft_part_t   in_im;
    logic                in_valid;
    ap_pkg::band_idx_t   band_idx;
    ap_pkg::energy_t     band_energy;
    logic                band_valid;

    // expected bands in arrival order
    int     exp_idx_q [$];
    longint exp_energy_q [$];
    longint exp_time_q [$];   // edge at which band_valid is seen high

    // band model state
    ap_pkg::bin_idx_t  model_bin = '0;
    ap_pkg::band_idx_t model_band = '0;
    longint            model_acc = 0;

    int cycle_cnt = 0;
    int bands_seen = 0;   // bands compared so far
    int seed_ret;

    spectrum_to_mel spectrum_to_mel_i (
        .clk         (clk),
        .rst         (rst),
        .in_re       (in_re),
        .in_im       (in_im),
        .in_valid    (in_valid),
        .band_idx    (band_idx),
        .band_energy (band_energy),
        .band_valid  (band_valid)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    // floor(sqrt(re^2 + im^2)) found one bit at a time from the top
    function automatic longint ref_mag(input ap_pkg::fft_part_t re, input ap_pkg::fft_part_t im);
        longint sq;
        longint r;
        longint t;
        sq = longint'(re) * longint'(re) + longint'(im) * longint'(im);
        r  = 0;
        for (int b = `AP_MAG_WIDTH - 1; b >= 0; b--) begin
            t = r | (longint'(1) << b);
            if (t * t <= sq) r = t;   // keep bit if square still fits
        end
        return r;
    endfunction

    task automatic record_bin(input ap_pkg::fft_part_t re, input ap_pkg::fft_part_t im);
        model_acc += ref_mag(re, im);
        if (model_bin == ap_pkg::band_last_bin(model_band)) begin
            exp_idx_q.push_back(model_band);
            exp_energy_q.push_back(model_acc);
            // band_valid rises 20 cycles after this edge and is sampled one edge later
            exp_time_q.push_back(longint'($time) + 21 * PERIOD);
            model_acc = 0;
            model_band++;                // wraps 7 -> 0
        end
        model_bin++;                     // wraps 63 -> 0
    endtask

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    task automatic drive_bin(input ap_pkg::fft_part_t re, input ap_pkg::fft_part_t im);
        @(posedge clk);
        in_re    <= re;
        in_im    <= im;
        in_valid <= 1'b1;
        record_bin(re, im);
    endtask

    function automatic ap_pkg::fft_part_t rand_part();
        logic [31:0] r;
        r = $urandom;
        return r[`AP_FFT_WIDTH-1:0];
    endfunction

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
            in_re    <= rand_part();   // junk while idle that must be ignored
            in_im    <= rand_part();
        end
    endtask

    // {re, im} for the directed corner bins
    function automatic logic [31:0] corner_pair(input int i);
        case (i)
            0:  return {16'sd0, 16'sd0};
            1:  return {16'sd0, 16'sd5};
            2:  return {16'sd0, -16'sd5};
            3:  return {16'sd7, 16'sd0};
            4:  return {-16'sd7, 16'sd0};
            5:  return {16'sd0, 16'h8000};      // -32768
            6:  return {16'h8000, 16'sd0};
            7:  return {16'h7fff, 16'sd0};      // +32767
            8:  return {16'sd0, 16'h7fff};
            9:  return {16'h7fff, 16'h7fff};
            10: return {16'h8000, 16'h8000};    // largest sum of squares
            11: return {16'h7fff, 16'h8000};
            12: return {16'h8000, 16'h7fff};
            13: return {16'h8001, 16'h8001};    // -32767 both
            14: return {16'sd3, 16'sd4};
            15: return {-16'sd3, -16'sd4};
            16: return {16'sd300, -16'sd400};
            17: return {-16'sd3000, 16'sd4000};
            18: return {16'sd5, 16'sd12};
            19: return {16'sd24000, -16'sd7000};  // exactly 25000
            default: return 32'd0;
        endcase
    endfunction

    task automatic run_corner_frame();
        logic [31:0] pair;
        int          k;
        for (int i = 0; i < `AP_NUM_BINS; i++) begin
            if (i < CORNER_N) begin
                pair = corner_pair(i);
                drive_bin(pair[31:16], pair[15:0]);
            end else begin
                k = i - CORNER_N + 1;   // 3,4 triangles scaled up with alternating signs
                if (k % 2 == 0) drive_bin(ap_pkg::fft_part_t'(3 * k * 150),
                                          ap_pkg::fft_part_t'(-4 * k * 150));
                else            drive_bin(ap_pkg::fft_part_t'(-3 * k * 150),
                                          ap_pkg::fft_part_t'(4 * k * 150));
            end
        end
    endtask

    // ------------------------------
    // compare and timeout
    // ------------------------------
    always @(posedge clk) begin : compare_bands
        int     exp_idx;
        longint exp_energy;
        longint exp_t;
        if (!rst && band_valid === 1'b1) begin
            assert (exp_idx_q.size() != 0)
                else stop_with_failure("band_valid pulsed while no band was expected");
            exp_idx    = exp_idx_q.pop_front();
            exp_energy = exp_energy_q.pop_front();
            exp_t      = exp_time_q.pop_front();
            assert (band_idx == exp_idx) else stop_with_failure($sformatf(
                "** Error at %0t: band_idx %0d, expected %0d", $time, band_idx, exp_idx));
            assert (band_energy == exp_energy) else stop_with_failure($sformatf(
                "** Error at %0t: band %0d energy %0d, expected %0d",
                $time, exp_idx, band_energy, exp_energy));
            assert ($time == exp_t) else stop_with_failure($sformatf(
                "** Error at %0t: band %0d arrived, expected at %0t", $time, exp_idx, exp_t));
            bands_seen <= bands_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        assert (cycle_cnt < CYCLE_LIMIT) else stop_with_failure($sformatf(
            "run timed out after %0d cycles before all bands arrived", cycle_cnt));
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        seed_ret = $urandom(32'hbfc6_0d46);
        clk      = 1'b0;
        rst      = 1'b1;
        in_re    = 16'h1234;         // junk held valid through reset
        in_im    = 16'h5678;
        in_valid = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst      <= 1'b0;
        in_valid <= 1'b0;

        drive_idle(IDLE_CYCLES - 1);   // no band may appear here
        $display("corner magnitudes");
        run_corner_frame();
        $display("timing frame");
        for (int i = 0; i < `AP_NUM_BINS; i++) begin
            drive_bin(ap_pkg::fft_part_t'(i * 100), ap_pkg::fft_part_t'(-i * 50));
        end
        $display("random back to back frames");
        repeat (3 * `AP_NUM_BINS) drive_bin(rand_part(), rand_part());
        $display("random frames with gaps");
        repeat (GAP_FRAMES * `AP_NUM_BINS) begin
            drive_idle($urandom_range(0, MAX_GAP));
            drive_bin(rand_part(), rand_part());
        end
        drive_idle(1);

        // eight bands per frame are due
        while (bands_seen < TOTAL_BANDS) @(posedge clk);
        repeat (TAIL_CYCLES) @(posedge clk);
        if (exp_idx_q.size() == 0 && bands_seen == TOTAL_BANDS) begin
            $display("No errors");
            $finish;
        end else begin
            stop_with_failure("band count or model queue wrong at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: hw/spectrum_to_mel.sv
// top level: fft bins in, mel-like band energies out
`timescale 1ns/1ps
`default_nettype none

module spectrum_to_mel (
    input  wire                    clk,
    input  wire                    rst,
    input  wire ap_pkg::fft_part_t in_re,
    input  wire ap_pkg::fft_part_t in_im,
    input  wire                    in_valid,      // one bin per strobe, gaps allowed
    output ap_pkg::band_idx_t      band_idx,
    output ap_pkg::energy_t        band_energy,
    output logic                   band_valid     // 20 cycles after a band's last bin
);

    // ------------------------------
    // bin magnitudes
    // ------------------------------
    ap_pkg::mag_t mag;
    logic         mag_valid;

    magnitude magnitude_i (
        .clk       (clk),
        .rst       (rst),
        .re        (in_re),
        .im        (in_im),
        .in_valid  (in_valid),
        .mag       (mag),         // 19 cycles behind in_valid
        .mag_valid (mag_valid)
    );

    // ------------------------------
    // band sums
    // ------------------------------
    band_accumulator band_accumulator_i (
        .clk         (clk),
        .rst         (rst),
        .mag         (mag),
        .mag_valid   (mag_valid),
        .band_idx    (band_idx),
        .band_energy (band_energy),
        .band_valid  (band_valid)   // one more cycle
    );

endmodule

`default_nettype wire

// File: hw/band_accumulator.sv
// bin counter, per-band magnitude sums and the band result strobe
`timescale 1ns/1ps
`default_nettype none

`include "ap_defines.svh"

module band_accumulator (
    input  wire                clk,
    input  wire                rst,
    input  wire ap_pkg::mag_t  mag,
    input  wire                mag_valid,
    output ap_pkg::band_idx_t  band_idx,      // band that just closed
    output ap_pkg::energy_t    band_energy,   // its complete sum
    output logic               band_valid     // one cycle after the band's last bin
);

    localparam ap_pkg::bin_idx_t LAST_BIN = ap_pkg::bin_idx_t'(`AP_NUM_BINS - 1);

    // ------------------------------
    // frame state
    // ------------------------------
    ap_pkg::bin_idx_t  bin_q;     // bin number of the next magnitude
    ap_pkg::band_idx_t band_q;    // band that bin_q falls into
    ap_pkg::energy_t   acc_q;     // running sum of the open band
    ap_pkg::energy_t   acc_sum;   // acc_q with the incoming magnitude
    logic              band_end;  // incoming bin closes its band

    // zero extend the magnitude to the energy width
    assign acc_sum  = acc_q + {{(`AP_ENERGY_WIDTH-`AP_MAG_WIDTH){1'b0}}, mag};
    assign band_end = (bin_q == ap_pkg::band_last_bin(band_q));

    // ------------------------------
    // accumulate and emit
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            bin_q       <= '0;
            band_q      <= '0;
            acc_q       <= '0;
            band_idx    <= '0;
            band_energy <= '0;
            band_valid  <= 1'b0;
        end else begin
            band_valid <= 1'b0;                 // strobe by default
            if (mag_valid) begin
                bin_q <= bin_q + 1'b1;          // wraps 63 -> 0
                if (band_end) begin
                    band_idx    <= band_q;
                    band_energy <= acc_sum;     // includes the closing bin
                    band_valid  <= 1'b1;
                    acc_q       <= '0;          // fresh sum for the next band
                    band_q      <= band_q + 1'b1;   // wraps 7 -> 0
                end else begin
                    acc_q <= acc_sum;
                end
            end
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    // band number may only restart where the frame restarts
    a_wrap_together: assert property (
        @(posedge clk) disable iff (rst)
        $changed(band_q) && (band_q == '0) |-> ($past(bin_q) == LAST_BIN) && (bin_q == '0)
    ) else $error("band_accumulator: band wrapped away from the frame end");

endmodule

`default_nettype wire

// File: hw/magnitude.sv
// exact bin magnitude: square, sum, then pipelined integer square root
`timescale 1ns/1ps
`default_nettype none

`include "ap_defines.svh"

module magnitude (
    input  wire                    clk,
    input  wire                    rst,
    input  wire ap_pkg::fft_part_t re,
    input  wire ap_pkg::fft_part_t im,
    input  wire                    in_valid,
    output ap_pkg::mag_t           mag,         // floor(sqrt(re^2 + im^2))
    output logic                   mag_valid    // in_valid delayed by 19 cycles
);

    localparam int PROD_W = 2 * `AP_FFT_WIDTH;

    // largest square, reached only by -32768
    localparam logic [PROD_W-1:0] SQ_MAX = 1 << (PROD_W - 2);

    // ------------------------------
    // stage 1 squares
    // ------------------------------
    logic signed [PROD_W-1:0] re_prod;   // signed full products
    logic signed [PROD_W-1:0] im_prod;
    logic [PROD_W-1:0]        re_sq_q;   // always >= 0 so kept unsigned
    logic [PROD_W-1:0]        im_sq_q;
    logic                     v1_q;

    // ------------------------------
    // stage 2 sum
    // ------------------------------
    ap_pkg::sq_t              sum_q;     // needs one bit over a single square
    logic                     v2_q;

    assign re_prod = re * re;   // operands sign extended to PROD_W
    assign im_prod = im * im;

    // valid pipe in front of the root
    always_ff @(posedge clk) begin
        if (rst) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v1_q <= in_valid;
            v2_q <= v1_q;
        end
    end

    // data pipe, follows v1_q / v2_q
    always_ff @(posedge clk) begin
        re_sq_q <= $unsigned(re_prod);
        im_sq_q <= $unsigned(im_prod);
        sum_q   <= {1'b0, re_sq_q} + {1'b0, im_sq_q};   // 2^31 max, no wrap
    end

    // ------------------------------
    // square root, 17 more cycles
    // ------------------------------
    int_sqrt int_sqrt_i (
        .clk        (clk),
        .rst        (rst),
        .in         (sum_q),
        .in_valid   (v2_q),
        .root       (mag),
        .root_valid (mag_valid)
    );

    // ------------------------------
    // checks
    // ------------------------------
    // sum_q sizing relies on each square staying at or under 2^30
    a_square_range: assert property (
        @(posedge clk) disable iff (rst)
        v1_q |-> (re_sq_q <= SQ_MAX) && (im_sq_q <= SQ_MAX)
    ) else $error("magnitude: square above (-32768)^2");

endmodule

`default_nettype wire

// File: hw/int_sqrt.sv
// pipelined restoring integer square root, one radicand accepted per cycle
`timescale 1ns/1ps
`default_nettype none

`include "ap_defines.svh"

module int_sqrt (
    input  wire              clk,
    input  wire              rst,
    input  wire ap_pkg::sq_t in,          // radicand
    input  wire              in_valid,
    output ap_pkg::mag_t     root,        // floor(sqrt(in))
    output logic             root_valid
);

    localparam int STAGES = `AP_SQRT_STAGES;  // one result bit per stage
    localparam int RAD_W  = 2 * STAGES;       // radicand padded to whole bit pairs
    localparam int REM_W  = STAGES + 1;       // remainder stays <= 2*root
    localparam int TRY_W  = STAGES + 3;       // shifted remainder plus borrow bit

    // ------------------------------
    // stage registers
    // ------------------------------
    logic [RAD_W-1:0] rad_q  [STAGES-1];  // bit pairs not yet consumed, msb first
    logic [REM_W-1:0] rem_q  [STAGES-1];  // last stage needs no remainder
    ap_pkg::mag_t     root_q [STAGES];    // partial root, grows one bit per stage
    logic             vld_q  [STAGES];

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        logic [RAD_W-1:0] rad_in;
        logic [REM_W-1:0] rem_in;
        ap_pkg::mag_t     root_in;
        logic             vld_in;
        logic [TRY_W-1:0] rem_sh;   // remainder with next pair brought down
        logic [TRY_W-1:0] trial;    // 4*root + 1
        logic [TRY_W-1:0] diff;
        logic             keep;     // next root bit

        if (s == 0) begin : g_first
            assign rad_in  = {{(RAD_W-`AP_SQ_WIDTH){1'b0}}, in};
            assign rem_in  = '0;
            assign root_in = '0;
            assign vld_in  = in_valid;
        end else begin : g_next
            assign rad_in  = rad_q[s-1];
            assign rem_in  = rem_q[s-1];
            assign root_in = root_q[s-1];
            assign vld_in  = vld_q[s-1];
        end

        assign rem_sh = {rem_in, rad_in[RAD_W-1 -: 2]};
        assign trial  = {1'b0, root_in, 2'b01};
        assign diff   = rem_sh - trial;
        assign keep   = ~diff[TRY_W-1];   // no borrow -> trial bit fits

        // valid travels beside the data
        always_ff @(posedge clk) begin
            if (rst) begin
                vld_q[s] <= 1'b0;
            end else begin
                vld_q[s] <= vld_in;
            end
        end

        always_ff @(posedge clk) begin
            root_q[s] <= {root_in[STAGES-2:0], keep};  // top bit is still zero here
        end

        if (s < STAGES - 1) begin : g_carry
            always_ff @(posedge clk) begin
                rad_q[s] <= rad_in << 2;                  // next pair to the top
                rem_q[s] <= keep ? diff[REM_W-1:0]        // restore on failed trial
                                 : rem_sh[REM_W-1:0];
            end
        end
    end

    assign root       = root_q[STAGES-1];
    assign root_valid = vld_q[STAGES-1];

    // ------------------------------
    // checks
    // ------------------------------
    // first accepted radicand needs all stages before it shows up
    a_no_early_root: assert property (
        @(posedge clk) $fell(rst) |-> !root_valid [*STAGES]
    ) else $error("int_sqrt: root_valid before the pipeline could fill");

endmodule

`default_nettype wire

// File: hw/ap_pkg.sv
// data types and band edge lookup shared by the mel band path
`default_nettype none

`include "ap_defines.svh"

package ap_pkg;

    // ------------------------------
    // payload types
    // ------------------------------
    typedef logic signed [`AP_FFT_WIDTH-1:0] fft_part_t;   // one fft component
    typedef logic [`AP_SQ_WIDTH-1:0]         sq_t;         // re^2 + im^2
    typedef logic [`AP_MAG_WIDTH-1:0]        mag_t;        // floor(sqrt(sq))
    typedef logic [`AP_ENERGY_WIDTH-1:0]     energy_t;     // sum over one band

    // ------------------------------
    // frame counters
    // ------------------------------
    typedef logic [$clog2(`AP_NUM_BINS)-1:0]  bin_idx_t;   // 0..63
    typedef logic [$clog2(`AP_NUM_BANDS)-1:0] band_idx_t;  // 0..7

    // last bin of each band
    // widths 2 3 4 5 7 9 13 21 grow roughly like the mel scale
    function automatic bin_idx_t band_last_bin(input band_idx_t band);
        bin_idx_t last;
        case (band)
            3'd0:    last = 6'd1;    // bins 0..1
            3'd1:    last = 6'd4;    // bins 2..4
            3'd2:    last = 6'd8;    // bins 5..8
            3'd3:    last = 6'd13;   // bins 9..13
            3'd4:    last = 6'd20;   // bins 14..20
            3'd5:    last = 6'd29;   // bins 21..29
            3'd6:    last = 6'd42;   // bins 30..42
            default: last = bin_idx_t'(`AP_NUM_BINS - 1);  // band 7 ends the frame
        endcase
        return last;
    endfunction

endpackage

`default_nettype wire

// File: hw/ap_defines.svh
// width, count and pipeline depth macros for the fft to mel band path
`ifndef AP_DEFINES_SVH
`define AP_DEFINES_SVH

// ------------------------------
// data widths
// ------------------------------
`define AP_FFT_WIDTH 16      // signed re or im part from the fft
`define AP_SQ_WIDTH 33       // re^2 + im^2 without overflow
`define AP_MAG_WIDTH 17      // ceil(AP_SQ_WIDTH / 2)
`define AP_ENERGY_WIDTH 24   // widest band holds 21 full scale magnitudes

// ------------------------------
// frame layout
// ------------------------------
`define AP_NUM_BINS 64       // bins per frame
`define AP_NUM_BANDS 8       // mel-like bands per frame

// ------------------------------
// square root pipeline
// ------------------------------
// one stage per result bit
`define AP_SQRT_STAGES `AP_MAG_WIDTH

// squares + sum ahead of the root
`define AP_PRE_STAGES 2

`endif
